//--- hw/aes_pkg.sv
package aes_pkg;

        localparam int blk_s   = 128;
        localparam int key_s   = 128;
        localparam int nr      = 10;
        localparam int round_w = 4;

        // Byte 0 is the most significant byte, column-major as in FIPS-197
        typedef logic [blk_s-1:0]   blk_t;
        typedef logic [round_w-1:0] round_t;

        function automatic logic [7:0] get_byte(blk_t s, int i);
                return s[blk_s-1-8*i -: 8];
        endfunction

        function automatic logic [7:0] rotl8(logic [7:0] b, int n);
                return (b << n) | (b >> (8 - n));
        endfunction

        function automatic logic [7:0] xtime(logic [7:0] b);
                return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
        endfunction

        function automatic logic [7:0] gmul(logic [7:0] a, logic [7:0] b);
                logic [7:0] p;
                logic [7:0] x;
                p = 8'h00;
                x = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i])
                                p = p ^ x;
                        x = xtime(x);
                end
                return p;
        endfunction

        // a^254 by repeated squaring, zero maps to zero
        function automatic logic [7:0] gf_inv(logic [7:0] a);
                logic [7:0] acc;
                logic [7:0] sq;
                acc = 8'h01;
                sq = a;
                for (int i = 1; i < 8; i++) begin
                        sq = gmul(sq, sq);
                        acc = gmul(acc, sq);
                end
                return acc;
        endfunction

        function automatic logic [7:0] sub_byte(logic [7:0] b);
                logic [7:0] y;
                y = gf_inv(b);
                return y ^ rotl8(y, 1) ^ rotl8(y, 2) ^ rotl8(y, 3) ^ rotl8(y, 4) ^ 8'h63;
        endfunction

        function automatic logic [7:0] inv_sub_byte(logic [7:0] b);
                return gf_inv(rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05);
        endfunction

        function automatic blk_t sub_bytes(blk_t s);
                blk_t r;
                for (int i = 0; i < 16; i++)
                        r[blk_s-1-8*i -: 8] = sub_byte(get_byte(s, i));
                return r;
        endfunction

        function automatic blk_t inv_sub_bytes(blk_t s);
                blk_t r;
                for (int i = 0; i < 16; i++)
                        r[blk_s-1-8*i -: 8] = inv_sub_byte(get_byte(s, i));
                return r;
        endfunction

        // Row r rotates left by r columns
        function automatic blk_t shift_rows(blk_t s);
                blk_t r;
                for (int c = 0; c < 4; c++)
                        for (int row = 0; row < 4; row++)
                                r[blk_s-1-8*(4*c+row) -: 8] = get_byte(s, 4*((c+row)%4) + row);
                return r;
        endfunction

        function automatic blk_t inv_shift_rows(blk_t s);
                blk_t r;
                for (int c = 0; c < 4; c++)
                        for (int row = 0; row < 4; row++)
                                r[blk_s-1-8*(4*c+row) -: 8] =
                                        get_byte(s, 4*((c-row+4)%4) + row);
                return r;
        endfunction

        function automatic blk_t mix_columns(blk_t s);
                blk_t r;
                logic [7:0] a [4];
                for (int c = 0; c < 4; c++) begin
                        for (int row = 0; row < 4; row++)
                                a[row] = get_byte(s, 4*c + row);
                        for (int row = 0; row < 4; row++)
                                r[blk_s-1-8*(4*c+row) -: 8] =
                                        xtime(a[row]) ^ xtime(a[(row+1)%4]) ^ a[(row+1)%4] ^
                                        a[(row+2)%4] ^ a[(row+3)%4];
                end
                return r;
        endfunction

        function automatic blk_t inv_mix_columns(blk_t s);
                blk_t r;
                logic [7:0] a [4];
                for (int c = 0; c < 4; c++) begin
                        for (int row = 0; row < 4; row++)
                                a[row] = get_byte(s, 4*c + row);
                        for (int row = 0; row < 4; row++)
                                r[blk_s-1-8*(4*c+row) -: 8] =
                                        gmul(a[row], 8'h0e) ^ gmul(a[(row+1)%4], 8'h0b) ^
                                        gmul(a[(row+2)%4], 8'h0d) ^ gmul(a[(row+3)%4], 8'h09);
                end
                return r;
        endfunction

        function automatic logic [31:0] sub_word(logic [31:0] w);
                return {sub_byte(w[31:24]), sub_byte(w[23:16]),
                        sub_byte(w[15:8]), sub_byte(w[7:0])};
        endfunction

        function automatic logic [31:0] rot_word(logic [31:0] w);
                return {w[23:0], w[31:24]};
        endfunction

        // Round constant for round 1 to nr, placed in the top byte
        function automatic logic [31:0] rcon(round_t r);
                logic [7:0] rc;
                rc = 8'h01;
                for (int i = 2; i <= nr; i++)
                        if (i <= r)
                                rc = xtime(rc);
                return {rc, 24'h000000};
        endfunction

endpackage

//--- hw/key_store.sv
`timescale 1ns/100ps

module key_store #(
        parameter int addr_width = 4,
        parameter int data_width = 128
) (
        input  logic                  clk,
        input  logic                  we,
        input  logic [addr_width-1:0] waddr,
        input  logic [addr_width-1:0] raddr,
        input  logic [data_width-1:0] wdata,
        output logic [data_width-1:0] rdata
);

        logic [data_width-1:0] mem [2**addr_width];

        always_ff @(posedge clk) begin
                if (we)
                        mem[waddr] <= wdata;
                rdata <= mem[raddr];
        end

endmodule

//--- hw/key_expander.sv
`timescale 1ns/100ps

module key_expander import aes_pkg::*; #(
        parameter int rounds = 10
) (
        input  logic   clk,
        input  logic   rst_n,
        input  logic   start,
        input  blk_t   key,
        output logic   we,
        output round_t round_no,
        output blk_t   round_key,
        output logic   done
);

        localparam int nk = key_s / 32;

        logic [31:0] w [nk];
        logic [31:0] nw [nk];
        logic [31:0] t;
        blk_t        next_key;
        logic        tail;

        // Next round key from the one being written now
        always_comb begin
                for (int i = 0; i < nk; i++)
                        w[i] = round_key[key_s-1-32*i -: 32];
                t = sub_word(rot_word(w[nk-1])) ^ rcon(round_t'(round_no + 1'b1));
                nw[0] = w[0] ^ t;
                for (int i = 1; i < nk; i++)
                        nw[i] = w[i] ^ nw[i-1];
                for (int i = 0; i < nk; i++)
                        next_key[key_s-1-32*i -: 32] = nw[i];
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        we       <= 1'b0;
                        round_no <= '0;
                        tail     <= 1'b0;
                        done     <= 1'b0;
                end else begin
                        done <= tail;
                        tail <= 1'b0;
                        if (start) begin
                                we       <= 1'b1;
                                round_no <= '0;
                        end else if (we) begin
                                // Last key goes out on this edge
                                if (round_no == round_t'(rounds)) begin
                                        we   <= 1'b0;
                                        tail <= 1'b1;
                                end else begin
                                        round_no <= round_no + 1'b1;
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (start)
                        round_key <= key;
                else if (we)
                        round_key <= next_key;
        end

endmodule

//--- hw/encrypt_rounds.sv
`timescale 1ns/100ps

module encrypt_rounds import aes_pkg::*; #(
        parameter int rounds = 10
) (
        input  logic   clk,
        input  logic   rst_n,
        input  logic   start,
        input  blk_t   plaintext,
        input  blk_t   round_key,
        output round_t round_no,
        output blk_t   ciphertext,
        output logic   done
);

        logic   active;
        logic   key_vld;
        round_t key_idx;
        blk_t   state;

        // Address runs one cycle ahead of the key it fetches
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        active   <= 1'b0;
                        round_no <= '0;
                        key_vld  <= 1'b0;
                        key_idx  <= '0;
                        done     <= 1'b0;
                end else begin
                        key_vld <= active;
                        key_idx <= round_no;
                        done    <= key_vld && key_idx == round_t'(rounds);
                        if (start) begin
                                active   <= 1'b1;
                                round_no <= '0;
                        end else if (active) begin
                                if (round_no == round_t'(rounds))
                                        active <= 1'b0;
                                else
                                        round_no <= round_no + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (key_vld) begin
                        if (key_idx == '0)
                                state <= plaintext ^ round_key;
                        else if (key_idx != round_t'(rounds))
                                state <= mix_columns(shift_rows(sub_bytes(state))) ^ round_key;
                end
        end

        // Final round skips the column mix
        always_ff @(posedge clk) begin
                if (key_vld && key_idx == round_t'(rounds))
                        ciphertext <= shift_rows(sub_bytes(state)) ^ round_key;
        end

endmodule

//--- hw/decrypt_rounds.sv
`timescale 1ns/100ps

module decrypt_rounds import aes_pkg::*; #(
        parameter int rounds = 10
) (
        input  logic   clk,
        input  logic   rst_n,
        input  logic   start,
        input  blk_t   ciphertext,
        input  blk_t   round_key,
        output round_t round_no,
        output blk_t   plaintext,
        output logic   done
);

        logic   active;
        logic   key_vld;
        round_t key_idx;
        blk_t   state;
        blk_t   inv_core;

        assign inv_core = inv_sub_bytes(inv_shift_rows(state)) ^ round_key;

        // Keys are read from the last one down to key 0
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        active   <= 1'b0;
                        round_no <= '0;
                        key_vld  <= 1'b0;
                        key_idx  <= '0;
                        done     <= 1'b0;
                end else begin
                        key_vld <= active;
                        key_idx <= round_no;
                        done    <= key_vld && key_idx == '0;
                        if (start) begin
                                active   <= 1'b1;
                                round_no <= round_t'(rounds);
                        end else if (active) begin
                                if (round_no == '0)
                                        active <= 1'b0;
                                else
                                        round_no <= round_no - 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (key_vld) begin
                        if (key_idx == round_t'(rounds))
                                state <= ciphertext ^ round_key;
                        else if (key_idx != '0)
                                state <= inv_mix_columns(inv_core);
                end
        end

        always_ff @(posedge clk) begin
                if (key_vld && key_idx == '0)
                        plaintext <= inv_core;
        end

endmodule

//--- hw/aes_top.sv
`timescale 1ns/100ps

module aes_top import aes_pkg::*; (
        input  logic clk,
        input  logic rst_n,
        input  logic en,
        input  logic cipher_mode,
        input  logic decipher_mode,
        input  logic key_exp_mode,
        input  blk_t aes_key,
        input  blk_t aes_in_blk,
        output blk_t aes_out_blk,
        output logic aes_op_in_progress,
        output logic en_o
);

        localparam logic [1:0] op_key = 2'd0;
        localparam logic [1:0] op_enc = 2'd1;
        localparam logic [1:0] op_dec = 2'd2;

        logic       accept;
        logic       start_key;
        logic       start_enc;
        logic       start_dec;
        logic [1:0] op;

        logic   key_we;
        round_t key_round_no;
        round_t enc_round_no;
        round_t dec_round_no;
        round_t raddr;
        blk_t   key_wdata;
        blk_t   round_key;
        blk_t   enc_out;
        blk_t   dec_out;
        blk_t   out_hold;
        logic   key_done;
        logic   enc_done;
        logic   dec_done;

        // A strobe while busy is dropped
        assign accept    = en && !aes_op_in_progress;
        assign start_key = accept && key_exp_mode;
        assign start_enc = accept && cipher_mode;
        assign start_dec = accept && decipher_mode;

        always_ff @(posedge clk) begin
                if (!rst_n)
                        op <= op_key;
                else if (accept)
                        op <= cipher_mode ? op_enc : decipher_mode ? op_dec : op_key;
        end

        always_comb begin
                case (op)
                        op_enc:  raddr = enc_round_no;
                        op_dec:  raddr = dec_round_no;
                        default: raddr = key_round_no;
                endcase
        end

        key_store #(
                .addr_width(round_w),
                .data_width(blk_s)
        ) u_key_store (
                .clk  (clk),
                .we   (key_we),
                .waddr(key_round_no),
                .raddr(raddr),
                .wdata(key_wdata),
                .rdata(round_key)
        );

        key_expander #(.rounds(nr)) u_key_expander (
                .clk      (clk),
                .rst_n    (rst_n),
                .start    (start_key),
                .key      (aes_key),
                .we       (key_we),
                .round_no (key_round_no),
                .round_key(key_wdata),
                .done     (key_done)
        );

        encrypt_rounds #(.rounds(nr)) u_encrypt (
                .clk       (clk),
                .rst_n     (rst_n),
                .start     (start_enc),
                .plaintext (aes_in_blk),
                .round_key (round_key),
                .round_no  (enc_round_no),
                .ciphertext(enc_out),
                .done      (enc_done)
        );

        decrypt_rounds #(.rounds(nr)) u_decrypt (
                .clk       (clk),
                .rst_n     (rst_n),
                .start     (start_dec),
                .ciphertext(aes_in_blk),
                .round_key (round_key),
                .round_no  (dec_round_no),
                .plaintext (dec_out),
                .done      (dec_done)
        );

        assign en_o = key_done | enc_done | dec_done;

        // Result only changes when a cipher engine finishes
        always_ff @(posedge clk) begin
                if (!rst_n)
                        out_hold <= '0;
                else if (enc_done)
                        out_hold <= enc_out;
                else if (dec_done)
                        out_hold <= dec_out;
        end

        // A finishing engine shows through in its done cycle
        always_comb begin
                if (enc_done)
                        aes_out_blk = enc_out;
                else if (dec_done)
                        aes_out_blk = dec_out;
                else
                        aes_out_blk = out_hold;
        end

        always_ff @(posedge clk) begin
                if (!rst_n)
                        aes_op_in_progress <= 1'b0;
                else if (accept)
                        aes_op_in_progress <= 1'b1;
                else if (en_o)
                        aes_op_in_progress <= 1'b0;
        end

endmodule

//--- verification/aes_top_assert.sv
`timescale 1ns/100ps

module aes_top_assert (
        input logic clk,
        input logic rst_n,
        input logic en_o,
        input logic aes_op_in_progress
);

        int fail_count = 0;

        // Done is a single-cycle pulse
        done_one_cycle: assert property (
                @(posedge clk) disable iff (!rst_n) en_o |=> !en_o
        ) else begin
                $error("en_o stayed high for more than one cycle");
                fail_count++;
        end

        done_while_busy: assert property (
                @(posedge clk) disable iff (!rst_n) en_o |-> aes_op_in_progress
        ) else begin
                $error("en_o pulsed while aes_op_in_progress was low");
                fail_count++;
        end

        idle_in_reset: assert property (
                @(posedge clk) !rst_n |=> !en_o && !aes_op_in_progress
        ) else begin
                $error("en_o or aes_op_in_progress high during reset");
                fail_count++;
        end

endmodule

bind aes_top aes_top_assert u_assert (
        .clk               (clk),
        .rst_n             (rst_n),
        .en_o              (en_o),
        .aes_op_in_progress(aes_op_in_progress)
);

//--- verification/aes_top_tb.sv
`timescale 1ns/100ps

module aes_top_tb import aes_pkg::*; ();

        localparam int clk_period   = 20;
        localparam int reset_cycles = 8;
        localparam int op_latency   = 12;
        localparam int op_limit     = 20;
        localparam int idle_cycles  = 20;
        localparam int n_vec        = 2;
        localparam int n_rand       = 20;
        localparam int timeout_ns   =
                (n_vec * 3 + n_rand * 2 + 4) * 20 * clk_period + reset_cycles * clk_period;

        localparam int mode_key = 0;
        localparam int mode_enc = 1;
        localparam int mode_dec = 2;

        // FIPS-197 vectors: key, plaintext, ciphertext
        blk_t vec_key [n_vec] = '{128'h000102030405060708090a0b0c0d0e0f,
                                  128'h2b7e151628aed2a6abf7158809cf4f3c};
        blk_t vec_pt  [n_vec] = '{128'h00112233445566778899aabbccddeeff,
                                  128'h3243f6a8885a308d313198a2e0370734};
        blk_t vec_ct  [n_vec] = '{128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                                  128'h3925841d02dc09fbdc118597196a0b32};

        logic clk;
        logic rst_n;
        logic en;
        logic cipher_mode;
        logic decipher_mode;
        logic key_exp_mode;
        blk_t aes_key;
        blk_t aes_in_blk;
        blk_t aes_out_blk;
        logic aes_op_in_progress;
        logic en_o;

        int   seed = 55037;
        blk_t last_out;

        aes_top uut (
                .clk               (clk),
                .rst_n             (rst_n),
                .en                (en),
                .cipher_mode       (cipher_mode),
                .decipher_mode     (decipher_mode),
                .key_exp_mode      (key_exp_mode),
                .aes_key           (aes_key),
                .aes_in_blk        (aes_in_blk),
                .aes_out_blk       (aes_out_blk),
                .aes_op_in_progress(aes_op_in_progress),
                .en_o              (en_o)
        );

        initial begin
                clk = 1'b0;
                forever #(clk_period / 2) clk = ~clk;
        end

        initial begin
                #(timeout_ns);
                $display("Simulation did not finish within %0d ns", timeout_ns);
                $display(">>> FAIL");
                $fatal(1, "watchdog expired");
        end

        initial begin
                wait (uut.u_assert.fail_count != 0);
                $display("A bound assertion on the control outputs failed");
                $display(">>> FAIL");
                $fatal(1, "assertion failure");
        end

        task automatic check_blk(input blk_t actual, input blk_t expected, input string what);
                if (actual !== expected) begin
                        $display("error at %0d ns: %s: got %h, expected %h",
                                 $time, what, actual, expected);
                        $display(">>> FAIL");
                        $fatal(1, "stopped at first mismatch");
                end
        endtask

        task automatic check_bit(input logic actual, input logic expected, input string what);
                if (actual !== expected) begin
                        $display("error at %0d ns: %s: got %b, expected %b",
                                 $time, what, actual, expected);
                        $display(">>> FAIL");
                        $fatal(1, "stopped at first mismatch");
                end
        endtask

        // One operation from strobe to the cycle after en_o; result is sampled with en_o
        task automatic run_op(input int mode, input blk_t key, input blk_t blk,
                              input bit intrude, output blk_t result);
                int cycles;
                bit seen;
                @(posedge clk);
                en            <= 1'b1;
                key_exp_mode  <= (mode == mode_key);
                cipher_mode   <= (mode == mode_enc);
                decipher_mode <= (mode == mode_dec);
                aes_key       <= key;
                aes_in_blk    <= blk;
                @(posedge clk);
                en <= 1'b0;
                // The first negedge follows the start edge and counts as cycle 0
                cycles = -1;
                seen   = 1'b0;
                while (!seen && cycles < op_limit) begin
                        @(negedge clk);
                        cycles++;
                        check_bit(aes_op_in_progress, 1'b1, "busy during operation");
                        if (en_o) begin
                                seen   = 1'b1;
                                result = aes_out_blk;
                        end else if (intrude && cycles == 4) begin
                                // Strobe with another mode while busy
                                @(posedge clk);
                                en            <= 1'b1;
                                key_exp_mode  <= 1'b1;
                                cipher_mode   <= 1'b0;
                                decipher_mode <= 1'b0;
                        end else if (intrude && cycles == 5) begin
                                @(posedge clk);
                                en <= 1'b0;
                        end
                end
                if (!seen) begin
                        $display("No done pulse on en_o within %0d cycles of the start",
                                 op_limit);
                        $display(">>> FAIL");
                        $fatal(1, "missing done pulse");
                end
                check_bit(cycles == op_latency, 1'b1,
                          $sformatf("done after %0d cycles instead of %0d", cycles, op_latency));
                @(negedge clk);
                check_bit(en_o, 1'b0, "en_o after done");
                check_bit(aes_op_in_progress, 1'b0, "busy after done");
                check_blk(aes_out_blk, result, "result held after done");
        endtask

        initial begin
                blk_t result;
                blk_t blk;
                blk_t ct;
                rst_n         = 1'b0;
                en            = 1'b0;
                cipher_mode   = 1'b0;
                decipher_mode = 1'b0;
                key_exp_mode  = 1'b0;
                aes_key       = '0;
                aes_in_blk    = '0;
                last_out      = '0;
                repeat (reset_cycles) @(posedge clk);
                rst_n <= 1'b1;
                @(negedge clk);
                check_bit(en_o, 1'b0, "en_o after reset");
                check_bit(aes_op_in_progress, 1'b0, "busy after reset");
                check_blk(aes_out_blk, '0, "result after reset");

                for (int i = 0; i < n_vec; i++) begin
                        run_op(mode_key, vec_key[i], vec_pt[i], 1'b0, result);
                        check_blk(result, last_out, "result kept over key expansion");
                        run_op(mode_enc, vec_key[i], vec_pt[i], 1'b0, result);
                        check_blk(result, vec_ct[i], $sformatf("ciphertext of vector %0d", i));
                        run_op(mode_dec, vec_key[i], vec_ct[i], 1'b0, result);
                        check_blk(result, vec_pt[i], $sformatf("plaintext of vector %0d", i));
                        last_out = vec_pt[i];
                end

                run_op(mode_key, vec_key[n_vec-1], '0, 1'b0, result);
                check_blk(result, last_out, "result kept over key expansion");

                for (int n = 0; n < n_rand; n++) begin
                        blk = {$random(seed), $random(seed), $random(seed), $random(seed)};
                        run_op(mode_enc, vec_key[n_vec-1], blk, 1'b0, ct);
                        run_op(mode_dec, vec_key[n_vec-1], ct, 1'b0, result);
                        check_blk(result, blk, $sformatf("round trip of block %0d", n));
                end

                run_op(mode_enc, vec_key[n_vec-1], vec_pt[n_vec-1], 1'b1, result);
                check_blk(result, vec_ct[n_vec-1], "ciphertext with ignored strobe");
                repeat (idle_cycles) begin
                        @(negedge clk);
                        check_bit(en_o, 1'b0, "no extra done pulse");
                        check_bit(aes_op_in_progress, 1'b0, "idle after ignored strobe");
                end

                $display(">>> PASS");
                $finish;
        end

endmodule

//--- aes_top.f
hw/aes_pkg.sv
hw/key_store.sv
hw/key_expander.sv
hw/encrypt_rounds.sv
hw/decrypt_rounds.sv
hw/aes_top.sv
verification/aes_top_assert.sv
verification/aes_top_tb.sv
